// ==== rtl/rom_pkg.sv ====
// shared constants and types for the four-slot ROM read subsystem
// import with rom_pkg::* in the module header of any block that needs them

package rom_pkg;

    localparam int NUM_SLOTS = 4;
    localparam int SDRAM_AW  = 22;  // counts 32-bit words
    localparam int SLOT_AW   = 16;  // item address of one client

    // cycles from reset or download release to ready
    localparam int READY_DELAY = 4;

    // per-slot item width, slot 0 first
    localparam int SLOT_DW [NUM_SLOTS] = '{8, 16, 32, 8};

    // word offset of each slot's region in SDRAM
    localparam logic [SDRAM_AW-1:0] SLOT_OFFSET [NUM_SLOTS] = '{
        22'h00_0000,
        22'h01_0000,
        22'h02_0000,
        22'h03_4000
    };

    // one SDRAM word seen as bytes, halfwords or the whole word
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
        logic [31:0]      w;
    } rom_word_u;

    // client access into a slot
    typedef struct packed {
        logic               cs;
        logic [SLOT_AW-1:0] addr;
    } slot_bus_t;

    // pending miss from a slot to the arbiter
    typedef struct packed {
        logic                req;
        logic [SDRAM_AW-1:0] addr;
    } slot_req_t;

    // read data coming back from the SDRAM controller
    typedef struct packed {
        logic      rdy;     // one cycle per read
        rom_word_u data;
    } sdram_rsp_t;

endpackage

// ==== rtl/rom_slot.sv ====
// one client slot: maps an item address onto an SDRAM word, keeps a
// one-word cache and asks the arbiter for a read on a miss
// DW selects the item width (8, 16 or 32), OFFSET places the slot in SDRAM

`timescale 1ns/1ps

module rom_slot import rom_pkg::*; #(
    parameter int                  DW     = 8,
    parameter logic [SDRAM_AW-1:0] OFFSET = '0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clr,     // drop cached word
    input  slot_bus_t  bus,
    input  logic       grant,
    input  sdram_rsp_t rsp,
    output slot_req_t  req,
    output logic [DW-1:0] dout,
    output logic       ok
);

    logic [SDRAM_AW-1:0] word_idx;
    logic [SDRAM_AW-1:0] req_addr;
    logic                hit;
    logic                load;

    logic                cache_vld;
    logic [SDRAM_AW-1:0] cache_tag;
    rom_word_u           cache_data;

    // word index and item select depend on the item width
    generate
        if (DW == 8) begin : g_byte
            logic [1:0] item_sel;
            assign word_idx = SDRAM_AW'(bus.addr[SLOT_AW-1:2]);
            assign item_sel = bus.addr[1:0];
            assign dout     = cache_data.b[item_sel];
        end else if (DW == 16) begin : g_half
            logic item_sel;
            assign word_idx = SDRAM_AW'(bus.addr[SLOT_AW-1:1]);
            assign item_sel = bus.addr[0];
            assign dout     = cache_data.h[item_sel];
        end else begin : g_word
            assign word_idx = SDRAM_AW'(bus.addr);
            assign dout     = cache_data.w;   // whole word, no select
        end
    endgenerate

    assign req_addr = OFFSET + word_idx;

    assign hit  = cache_vld && (cache_tag == req_addr);
    assign ok   = bus.cs && hit;
    assign req  = slot_req_t'{req: bus.cs && !hit, addr: req_addr};

    // data for this slot arrives only while it holds the grant
    assign load = grant && rsp.rdy;

    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            cache_vld <= 1'b0;
        end else if (load) begin
            cache_vld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            cache_tag  <= req_addr;    // client holds addr until ok
            cache_data <= rsp.data;
        end
    end

endmodule

// ==== rtl/rom_arbiter.sv ====
// fixed-priority arbiter for the shared SDRAM read port, slot 0 wins
// issues one read at a time over the req/ack/data_rdy handshake,
// drives refresh enable and raises ready after each restart

`timescale 1ns/1ps

module rom_arbiter import rom_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        downloading,
    input  logic                        vblank,
    input  slot_req_t [NUM_SLOTS-1:0]   reqs,
    input  logic                        sdram_ack,
    input  logic                        rsp_rdy,
    output logic [NUM_SLOTS-1:0]        grant,
    output logic                        sdram_req,
    output logic [SDRAM_AW-1:0]         sdram_addr,
    output logic                        refresh_en,
    output logic                        ready
);

    logic [NUM_SLOTS-1:0]   active;
    logic [NUM_SLOTS-1:0]   next_grant;
    logic [SDRAM_AW-1:0]    next_addr;
    logic                   take_next;
    logic [READY_DELAY-2:0] ready_cnt;   // shifts in ones, top bit feeds ready

    // a slot already being served does not compete again
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            active[i] = reqs[i].req && !grant[i];
        end
    end

    // walk down so the lowest active slot is the one left standing
    always_comb begin
        next_grant = '0;
        next_addr  = reqs[0].addr;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (active[i]) begin
                next_grant    = '0;
                next_grant[i] = 1'b1;
                next_addr     = reqs[i].addr;
            end
        end
    end

    // free to pick when idle or when the current read completes
    assign take_next = (grant == '0) || rsp_rdy;

    always_ff @(posedge clk) begin
        if (!rst_n || downloading) begin
            grant      <= '0;
            sdram_req  <= 1'b0;
            refresh_en <= 1'b1;   // controller keeps refreshing meanwhile
            ready      <= 1'b0;
            ready_cnt  <= '0;
        end else begin
            {ready, ready_cnt} <= {ready_cnt, 1'b1};
            refresh_en <= 1'b0;
            if (sdram_ack) begin
                sdram_req <= 1'b0;
            end
            if (take_next) begin
                grant     <= next_grant;
                sdram_req <= |active;
                if (!(|active)) begin
                    refresh_en <= vblank;   // idle, refresh only in vblank
                end
            end
        end
    end

    // address stays put for the whole read
    always_ff @(posedge clk) begin
        if (take_next && |active) begin
            sdram_addr <= next_addr;
        end
    end

endmodule

// ==== rtl/rom_top.sv ====
// ROM access subsystem top: four client slots sharing one SDRAM read port
// the SDRAM controller sits outside and answers sdram_req/sdram_addr

`timescale 1ns/1ps

module rom_top import rom_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  slot_bus_t [NUM_SLOTS-1:0]   slot_bus,
    input  logic                        vblank,
    input  logic                        downloading,
    input  logic                        sdram_ack,
    input  sdram_rsp_t                  sdram_rsp,
    output logic [SLOT_DW[0]-1:0]       slot0_dout,
    output logic [SLOT_DW[1]-1:0]       slot1_dout,
    output logic [SLOT_DW[2]-1:0]       slot2_dout,
    output logic [SLOT_DW[3]-1:0]       slot3_dout,
    output logic [NUM_SLOTS-1:0]        slot_ok,
    output logic                        sdram_req,
    output logic [SDRAM_AW-1:0]         sdram_addr,
    output logic                        refresh_en,
    output logic                        ready
);

    slot_req_t [NUM_SLOTS-1:0] slot_req;
    logic      [NUM_SLOTS-1:0] grant;

    rom_slot #(.DW(SLOT_DW[0]), .OFFSET(SLOT_OFFSET[0])) i_slot0 (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (downloading),   // new ROM contents invalidate the cache
        .bus   (slot_bus[0]),
        .grant (grant[0]),
        .rsp   (sdram_rsp),
        .req   (slot_req[0]),
        .dout  (slot0_dout),
        .ok    (slot_ok[0])
    );

    rom_slot #(.DW(SLOT_DW[1]), .OFFSET(SLOT_OFFSET[1])) i_slot1 (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (downloading),
        .bus   (slot_bus[1]),
        .grant (grant[1]),
        .rsp   (sdram_rsp),
        .req   (slot_req[1]),
        .dout  (slot1_dout),
        .ok    (slot_ok[1])
    );

    rom_slot #(.DW(SLOT_DW[2]), .OFFSET(SLOT_OFFSET[2])) i_slot2 (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (downloading),
        .bus   (slot_bus[2]),
        .grant (grant[2]),
        .rsp   (sdram_rsp),
        .req   (slot_req[2]),
        .dout  (slot2_dout),
        .ok    (slot_ok[2])
    );

    rom_slot #(.DW(SLOT_DW[3]), .OFFSET(SLOT_OFFSET[3])) i_slot3 (
        .clk   (clk),
        .rst_n (rst_n),
        .clr   (downloading),
        .bus   (slot_bus[3]),
        .grant (grant[3]),
        .rsp   (sdram_rsp),
        .req   (slot_req[3]),
        .dout  (slot3_dout),
        .ok    (slot_ok[3])
    );

    rom_arbiter i_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .vblank      (vblank),
        .reqs        (slot_req),
        .sdram_ack   (sdram_ack),
        .rsp_rdy     (sdram_rsp.rdy),
        .grant       (grant),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .refresh_en  (refresh_en),
        .ready       (ready)
    );

endmodule

// ==== verif/tb_sdram_model.sv ====
// SDRAM read model for the ROM testbench: acks a request after 0 to 3 cycles
// and returns data 1 to 4 cycles after the ack, data depends on address only

`timescale 1ns/1ps

module tb_sdram_model import rom_pkg::*; (
    input  logic                clk,
    input  logic                sdram_req,
    input  logic [SDRAM_AW-1:0] sdram_addr,
    output logic                sdram_ack,
    output sdram_rsp_t          sdram_rsp
);

    localparam logic [31:0] SEED = 32'd38990;

    logic [31:0]         lcg_state;
    logic [SDRAM_AW-1:0] rd_addr;
    int                  ack_delay;
    int                  rdy_delay;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // ROM contents, fixed per word address
    function automatic logic [31:0] mix_word(input logic [SDRAM_AW-1:0] word_addr);
        return (32'(word_addr) * 32'h9e37_79b1) ^ 32'ha5c3_0f96;
    endfunction

    initial begin
        lcg_state = SEED;
        sdram_ack = 1'b0;
        sdram_rsp = '0;
        forever begin
            @(negedge clk);
            if (sdram_req === 1'b1) begin
                rd_addr   = sdram_addr;   // held by the arbiter until rdy
                lcg_state = lcg_next(lcg_state);
                ack_delay = int'(lcg_state[17:16]);
                lcg_state = lcg_next(lcg_state);
                rdy_delay = int'(lcg_state[17:16]) + 1;
                repeat (ack_delay) @(negedge clk);
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
                repeat (rdy_delay - 1) @(negedge clk);
                sdram_rsp.rdy    = 1'b1;  // one cycle wide
                sdram_rsp.data.w = mix_word(rd_addr);
                @(negedge clk);
                sdram_rsp = '0;
            end
        end
    end

endmodule

// ==== verif/tb_rom_top.sv ====
// testbench for the ROM access subsystem: applies a table of slot accesses
// against the SDRAM model, then checks priority, refresh enable and download

`timescale 1ns/1ps

module tb_rom_top import rom_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 64;
    localparam int READY_CYCLES   = 4;
    localparam int NUM_ROWS       = 13;
    localparam int ROWS_BEFORE_DL = 10;

    typedef struct packed {
        logic [1:0]         slot;
        logic [SLOT_AW-1:0] addr;
        logic               vblank;
        logic               exp_req;   // miss expected
    } access_row_t;

    // rows from ROWS_BEFORE_DL on run after the download pulse
    access_row_t rows [NUM_ROWS] = '{
        '{2'd0, 16'h0011, 1'b0, 1'b1},
        '{2'd0, 16'h0013, 1'b1, 1'b0},
        '{2'd0, 16'h0014, 1'b0, 1'b1},
        '{2'd1, 16'h0235, 1'b1, 1'b1},
        '{2'd1, 16'h0234, 1'b0, 1'b0},
        '{2'd2, 16'h1234, 1'b1, 1'b1},
        '{2'd2, 16'h1234, 1'b0, 1'b0},
        '{2'd3, 16'hfffe, 1'b1, 1'b1},
        '{2'd3, 16'hfffc, 1'b0, 1'b0},
        '{2'd1, 16'h0236, 1'b1, 1'b1},
        '{2'd1, 16'h0236, 1'b0, 1'b1},   // cached before the download
        '{2'd1, 16'h0237, 1'b1, 1'b0},
        '{2'd2, 16'h1234, 1'b0, 1'b1}
    };

    logic                      clk;
    logic                      rst_n;
    logic                      vblank;
    logic                      downloading;
    logic                      sdram_ack;
    slot_bus_t [NUM_SLOTS-1:0] slot_bus;
    sdram_rsp_t                sdram_rsp;
    logic [SLOT_DW[0]-1:0]     slot0_dout;
    logic [SLOT_DW[1]-1:0]     slot1_dout;
    logic [SLOT_DW[2]-1:0]     slot2_dout;
    logic [SLOT_DW[3]-1:0]     slot3_dout;
    logic [NUM_SLOTS-1:0]      slot_ok;
    logic                      sdram_req;
    logic [SDRAM_AW-1:0]       sdram_addr;
    logic                      refresh_en;
    logic                      ready;
    logic [31:0]               dout_word [NUM_SLOTS];
    int                        row;

    assign dout_word[0] = 32'(slot0_dout);
    assign dout_word[1] = 32'(slot1_dout);
    assign dout_word[2] = 32'(slot2_dout);
    assign dout_word[3] = 32'(slot3_dout);

    always #10 clk = ~clk;

    rom_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .slot_bus    (slot_bus),
        .vblank      (vblank),
        .downloading (downloading),
        .sdram_ack   (sdram_ack),
        .sdram_rsp   (sdram_rsp),
        .slot0_dout  (slot0_dout),
        .slot1_dout  (slot1_dout),
        .slot2_dout  (slot2_dout),
        .slot3_dout  (slot3_dout),
        .slot_ok     (slot_ok),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .refresh_en  (refresh_en),
        .ready       (ready)
    );

    tb_sdram_model i_sdram (
        .clk        (clk),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .sdram_rsp  (sdram_rsp)
    );

    // expected ROM word, same mixing as the SDRAM model
    function automatic logic [31:0] rom_word(input logic [SDRAM_AW-1:0] word_addr);
        return (32'(word_addr) * 32'h9e37_79b1) ^ 32'ha5c3_0f96;
    endfunction

    function automatic logic [SDRAM_AW-1:0] word_addr_of(input int slot,
                                                         input logic [SLOT_AW-1:0] addr);
        logic [SDRAM_AW-1:0] idx;
        case (SLOT_DW[slot])
            8:       idx = SDRAM_AW'(addr >> 2);
            16:      idx = SDRAM_AW'(addr >> 1);
            default: idx = SDRAM_AW'(addr);
        endcase
        return SLOT_OFFSET[slot] + idx;
    endfunction

    function automatic logic [31:0] expected_item(input int slot,
                                                  input logic [SLOT_AW-1:0] addr);
        logic [31:0] word;
        logic [31:0] item;
        word = rom_word(word_addr_of(slot, addr));
        case (SLOT_DW[slot])
            8:       item = (word >> (8 * addr[1:0])) & 32'h0000_00ff;
            16:      item = (word >> (16 * addr[0])) & 32'h0000_ffff;
            default: item = word;
        endcase
        return item;
    endfunction

    task automatic fail_run(input string reason);
        $display("tests failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            fail_run({"wrong value on ", name});
        end
    endtask

    task automatic wait_req(input logic level);
        int cycles;
        cycles = 0;
        while (sdram_req !== level) begin
            if (cycles == TIMEOUT_CYCLES) begin
                fail_run("sdram_req did not reach the awaited level in time");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_ok(input logic [NUM_SLOTS-1:0] mask);
        int cycles;
        cycles = 0;
        while ((slot_ok & mask) !== mask) begin
            if (cycles == TIMEOUT_CYCLES) begin
                fail_run("slot_ok did not come back after a miss");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // ready must rise on the fourth edge after release
    task automatic check_ready_ramp();
        int i;
        for (i = 1; i <= READY_CYCLES; i++) begin
            @(negedge clk);
            check_value("ready", 32'(ready), 32'(i == READY_CYCLES));
            check_value("sdram_req", 32'(sdram_req), 32'(0));
            check_value("refresh_en", 32'(refresh_en), 32'(1));
        end
    endtask

    task automatic apply_row(input access_row_t r);
        int                   slot;
        logic [NUM_SLOTS-1:0] hot;
        slot           = int'(r.slot);
        hot            = '0;
        hot[slot]      = 1'b1;
        vblank         = r.vblank;
        slot_bus[slot].cs   = 1'b1;
        slot_bus[slot].addr = r.addr;
        #1;
        if (r.exp_req) begin
            check_value("slot_ok", 32'(slot_ok), 32'(0));
            wait_req(1'b1);
            check_value("sdram_addr", 32'(sdram_addr), 32'(word_addr_of(slot, r.addr)));
            wait_ok(hot);
        end else begin
            check_value("slot_ok", 32'(slot_ok), 32'(hot));   // hit, same cycle
            @(negedge clk);
            check_value("sdram_req", 32'(sdram_req), 32'(0));
        end
        check_value($sformatf("slot%0d_dout", slot), dout_word[slot],
                    expected_item(slot, r.addr));
        slot_bus[slot].cs = 1'b0;
        @(negedge clk);
        check_value("refresh_en", 32'(refresh_en), 32'(r.vblank));
    endtask

    // slots 3 and 0 miss together, slot 0 goes first
    task automatic check_priority();
        logic [SLOT_AW-1:0] addr0;
        logic [SLOT_AW-1:0] addr3;
        addr0  = 16'h0100;
        addr3  = 16'h0020;
        vblank = 1'b0;
        slot_bus[0] = '{cs: 1'b1, addr: addr0};
        slot_bus[3] = '{cs: 1'b1, addr: addr3};
        wait_req(1'b1);
        check_value("sdram_addr", 32'(sdram_addr), 32'(word_addr_of(0, addr0)));
        wait_req(1'b0);
        wait_req(1'b1);
        check_value("sdram_addr", 32'(sdram_addr), 32'(word_addr_of(3, addr3)));
        wait_ok(4'b1001);
        check_value("slot0_dout", dout_word[0], expected_item(0, addr0));
        check_value("slot3_dout", dout_word[3], expected_item(3, addr3));
        slot_bus = '0;
        @(negedge clk);
        check_value("refresh_en", 32'(refresh_en), 32'(0));
    endtask

    task automatic pulse_download();
        int i;
        downloading = 1'b1;
        vblank      = 1'b0;
        for (i = 0; i < 3; i++) begin
            @(negedge clk);
            check_value("refresh_en", 32'(refresh_en), 32'(1));
            check_value("sdram_req", 32'(sdram_req), 32'(0));
            check_value("ready", 32'(ready), 32'(0));
        end
        downloading = 1'b0;
        vblank      = 1'b1;   // keeps refresh on while ready ramps
        check_ready_ramp();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        vblank      = 1'b1;
        downloading = 1'b0;
        slot_bus    = '0;
        repeat (3) begin
            @(negedge clk);
            check_value("sdram_req", 32'(sdram_req), 32'(0));
            check_value("refresh_en", 32'(refresh_en), 32'(1));
            check_value("ready", 32'(ready), 32'(0));
        end
        rst_n = 1'b1;
        check_ready_ramp();
        for (row = 0; row < ROWS_BEFORE_DL; row++) begin
            apply_row(rows[row]);
        end
        check_priority();
        pulse_download();
        for (row = ROWS_BEFORE_DL; row < NUM_ROWS; row++) begin
            apply_row(rows[row]);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== src.f ====
rtl/rom_pkg.sv
rtl/rom_slot.sv
rtl/rom_arbiter.sv
rtl/rom_top.sv
verif/tb_sdram_model.sv
verif/tb_rom_top.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_rom_top
FILELIST  := src.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

# sources taken from the file list, include directories skipped
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
